/* corr_pkg.sv */
// shared sizes, uart timing, opcodes, frame constants and counter map of the correlator
`default_nettype none

package corr_pkg;

	// ------------------------------------------------------------------
	// sizes
	// ------------------------------------------------------------------
	localparam int num_inputs    = 4;
	localparam int num_lags      = 4;
	localparam int num_pairs     = 6;
	localparam int counter_width = 16;
	localparam int num_counters  = num_inputs + num_inputs * num_lags + num_pairs; // 26
	localparam int addr_width    = 5;

	// uart bit period in intclk cycles
	localparam int baud_cycles = 16;

	// window length is base_window << arg for arg 0..7
	localparam int base_window = 64;
	localparam int win_width   = $clog2(base_window) + 8;

	localparam logic [7:0] frame_header = 8'hA5;

	// ------------------------------------------------------------------
	// counter index map, frame order
	// ------------------------------------------------------------------
	localparam int pulse_base = 0;
	localparam int auto_base  = num_inputs;                          // 4 + 4*i + k
	localparam int pair_base  = num_inputs + num_inputs * num_lags;  // 20

	// pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	localparam int pair_a [num_pairs] = '{0, 0, 0, 1, 1, 2};
	localparam int pair_b [num_pairs] = '{1, 2, 3, 2, 3, 3};

	// upper nibble of a command byte
	typedef enum logic [3:0] {
		op_invert    = 4'd1, // low nibble is the invert mask
		op_integrate = 4'd2  // low three bits are the window argument
	} cmd_op_t;

	typedef enum logic [1:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop
	} rx_state_t;

	typedef enum logic [2:0] {
		fs_idle,
		fs_header,
		fs_count,
		fs_hi,
		fs_lo,
		fs_csum
	} frame_state_t;

endpackage

`default_nettype wire

/* corr_rd_if.sv */
// snapshot read port between the correlator and the frame transmitter
`timescale 1ns/100ps
`default_nettype none

interface corr_rd_if;
	import corr_pkg::*;

	logic                     snap_ready; // one cycle, new snapshot stored
	logic                     busy;       // window open
	logic [addr_width-1:0]    rd_addr;
	logic [counter_width-1:0] rd_data;    // one cycle after rd_addr

	modport correlator (
		output snap_ready,
		output busy,
		input  rd_addr,
		output rd_data
	);

	modport reader (
		input  snap_ready,
		input  busy,
		output rd_addr,
		input  rd_data
	);

endinterface

`default_nettype wire

/* uart_rx.sv */
// uart receiver for 8N1 frames that gives one byte and a strobe per good frame
`timescale 1ns/100ps
`default_nettype none

module uart_rx (
	input  wire        intclk,
	input  wire        arst_n,
	input  wire        rx,
	output logic [7:0] rx_byte,
	output logic       rx_stb
);
	import corr_pkg::*;

	rx_state_t                      state;
	logic                           rx_meta;
	logic                           rx_sync;
	logic [$clog2(baud_cycles)-1:0] baud_cnt;
	logic [2:0]                     bit_idx;
	logic [7:0]                     shift;

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			rx_meta  <= 1'b1;
			rx_sync  <= 1'b1;
			state    <= rx_idle;
			baud_cnt <= '0;
			bit_idx  <= '0;
			shift    <= '0;
			rx_byte  <= '0;
			rx_stb   <= 1'b0;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
			rx_stb  <= 1'b0;
			baud_cnt <= baud_cnt + 1'b1;
			case (state)
				rx_idle: begin
					baud_cnt <= '0;
					if (!rx_sync)
						state <= rx_start;
				end
				rx_start: if (baud_cnt == baud_cycles / 2 - 1) begin
					baud_cnt <= '0;
					bit_idx  <= '0;
					state    <= rx_sync ? rx_idle : rx_data; // a glitch is not a start bit
				end
				rx_data: if (baud_cnt == baud_cycles - 1) begin
					baud_cnt <= '0;
					shift    <= {rx_sync, shift[7:1]}; // lsb first
					bit_idx  <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= rx_stop;
				end
				rx_stop: if (baud_cnt == baud_cycles - 1) begin
					state <= rx_idle;
					if (rx_sync) begin // framing error drops the byte
						rx_byte <= shift;
						rx_stb  <= 1'b1;
					end
				end
				default: state <= rx_idle;
			endcase
		end
	end

	a_stb_one_cycle: assert property (@(posedge intclk) disable iff (!arst_n)
		rx_stb |=> !rx_stb);

endmodule

`default_nettype wire

/* uart_tx.sv */
// uart transmitter that sends one 8N1 byte per strobe
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
	input  wire        intclk,
	input  wire        arst_n,
	input  wire  [7:0] tx_byte,
	input  wire        tx_stb,
	output logic       tx,
	output logic       tx_busy
);
	import corr_pkg::*;

	logic [$clog2(baud_cycles)-1:0] baud_cnt;
	logic [3:0]                     bit_cnt; // 0 start, 1..8 data, 9 stop
	logic [8:0]                     shift;   // data then stop bit

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			tx       <= 1'b1;
			tx_busy  <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			shift    <= '1;
		end else if (!tx_busy) begin
			if (tx_stb) begin
				tx       <= 1'b0; // start bit
				tx_busy  <= 1'b1;
				shift    <= {1'b1, tx_byte};
				baud_cnt <= '0;
				bit_cnt  <= '0;
			end
		end else if (baud_cnt == baud_cycles - 1) begin
			baud_cnt <= '0;
			if (bit_cnt == 4'd9) begin
				tx      <= 1'b1;
				tx_busy <= 1'b0;
			end else begin
				tx      <= shift[0];
				shift   <= {1'b1, shift[8:1]};
				bit_cnt <= bit_cnt + 1'b1;
			end
		end else begin
			baud_cnt <= baud_cnt + 1'b1;
		end
	end

	// the frame transmitter must hold off while a byte is on the line
	a_no_stb_busy: assert property (@(posedge intclk) disable iff (!arst_n)
		tx_stb |-> !tx_busy);

endmodule

`default_nettype wire

/* cmd_parser.sv */
// command decoder that sets the invert mask and window argument and starts a window
`timescale 1ns/100ps
`default_nettype none

module cmd_parser (
	input  wire                              intclk,
	input  wire                              arst_n,
	input  wire  [7:0]                       rx_byte,
	input  wire                              rx_stb,
	output logic [corr_pkg::num_inputs-1:0]  invert_mask,
	output logic [2:0]                       window_arg,
	output logic                             start
);
	import corr_pkg::*;

	cmd_op_t op;

	assign op = cmd_op_t'(rx_byte[7:4]);

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			invert_mask <= '0;
			window_arg  <= '0;
			start       <= 1'b0;
		end else begin
			start <= 1'b0;
			if (rx_stb) begin
				case (op)
					op_invert: invert_mask <= rx_byte[num_inputs-1:0];
					op_integrate: begin
						window_arg <= rx_byte[2:0];
						start      <= 1'b1;
					end
					default: ; // unknown opcodes are ignored
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* lag_correlator.sv */
// lag correlator with delay lines, window timer, saturating counters and snapshot
`timescale 1ns/100ps
`default_nettype none

module lag_correlator (
	input  wire                              intclk,
	input  wire                              arst_n,
	input  wire  [corr_pkg::num_inputs-1:0]  det_in,
	input  wire  [corr_pkg::num_inputs-1:0]  invert_mask,
	input  wire  [2:0]                       window_arg,
	input  wire                              start,
	corr_rd_if.correlator                    rd
);
	import corr_pkg::*;

	logic [num_inputs-1:0]    smp;                // sampled, inverted inputs
	logic [num_lags-1:0]      dly [num_inputs];   // dly[i][k] is smp[i] k+1 samples back
	logic                     busy;
	logic                     snap_ready;
	logic [win_width-1:0]     win_cnt;
	logic                     last;
	logic [num_counters-1:0]  hit;
	logic [counter_width-1:0] cnt      [num_counters];
	logic [counter_width-1:0] cnt_next [num_counters];
	logic [counter_width-1:0] snap     [num_counters];

	assign last          = busy && (win_cnt == '0);
	assign rd.busy       = busy;
	assign rd.snap_ready = snap_ready;

	// ------------------------------------------------------------------
	// sampling and window timer
	// ------------------------------------------------------------------
	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			smp        <= '0;
			busy       <= 1'b0;
			snap_ready <= 1'b0;
			win_cnt    <= '0;
			for (int i = 0; i < num_inputs; i++)
				dly[i] <= '0;
		end else begin
			smp <= det_in ^ invert_mask;
			for (int i = 0; i < num_inputs; i++)
				dly[i] <= {dly[i][num_lags-2:0], smp[i]}; // runs outside the window too
			snap_ready <= last;
			if (start && !busy) begin
				busy    <= 1'b1;
				win_cnt <= (win_width'(base_window) << window_arg) - win_width'(1);
			end else if (last) begin
				busy <= 1'b0;
			end else if (busy) begin
				win_cnt <= win_cnt - 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------
	// hit vector in frame order
	// ------------------------------------------------------------------
	for (genvar i = 0; i < num_inputs; i++) begin : g_in
		assign hit[pulse_base + i] = smp[i];
		for (genvar k = 0; k < num_lags; k++) begin : g_lag
			assign hit[auto_base + num_lags * i + k] = smp[i] & dly[i][k];
		end
	end

	for (genvar p = 0; p < num_pairs; p++) begin : g_pair
		assign hit[pair_base + p] = smp[pair_a[p]] & smp[pair_b[p]]; // lag 0
	end

	always_comb begin
		for (int j = 0; j < num_counters; j++)
			cnt_next[j] = (hit[j] && cnt[j] != '1) ? cnt[j] + 1'b1 : cnt[j];
	end

	always_ff @(posedge intclk) begin
		for (int j = 0; j < num_counters; j++) begin
			if (start && !busy)
				cnt[j] <= '0;
			else if (busy)
				cnt[j] <= cnt_next[j];
			if (last)
				snap[j] <= cnt_next[j]; // includes the final sample
		end
		rd.rd_data <= snap[rd.rd_addr];
	end

	// a new snapshot only appears once the window has closed
	a_snap_idle: assert property (@(posedge intclk) disable iff (!arst_n)
		rd.snap_ready |-> !rd.busy);

endmodule

`default_nettype wire

/* frame_tx.sv */
// frame transmitter that sends header, count, counters high byte first and an xor checksum
`timescale 1ns/100ps
`default_nettype none

module frame_tx (
	input  wire        intclk,
	input  wire        arst_n,
	corr_rd_if.reader  rd,
	output logic [7:0] tx_byte,
	output logic       tx_stb,
	input  wire        tx_busy
);
	import corr_pkg::*;

	frame_state_t state;
	logic [7:0]   csum;
	logic         can_send;

	// busy rises a cycle after the strobe so the strobe cycle is skipped too
	assign can_send = !tx_busy && !tx_stb;

	always_ff @(posedge intclk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= fs_idle;
			rd.rd_addr <= '0;
			csum       <= '0;
			tx_byte    <= '0;
			tx_stb     <= 1'b0;
		end else begin
			tx_stb <= 1'b0;
			case (state)
				fs_idle: if (rd.snap_ready) begin
					rd.rd_addr <= '0;
					csum       <= '0;
					state      <= fs_header;
				end
				fs_header: if (can_send) begin
					tx_byte <= frame_header; // not part of the checksum
					tx_stb  <= 1'b1;
					state   <= fs_count;
				end
				fs_count: if (can_send) begin
					tx_byte <= 8'(num_counters);
					tx_stb  <= 1'b1;
					csum    <= csum ^ 8'(num_counters);
					state   <= fs_hi;
				end
				fs_hi: if (can_send) begin
					tx_byte <= rd.rd_data[15:8];
					tx_stb  <= 1'b1;
					csum    <= csum ^ rd.rd_data[15:8];
					state   <= fs_lo;
				end
				fs_lo: if (can_send) begin
					tx_byte <= rd.rd_data[7:0];
					tx_stb  <= 1'b1;
					csum    <= csum ^ rd.rd_data[7:0];
					if (rd.rd_addr == addr_width'(num_counters - 1)) begin
						state <= fs_csum;
					end else begin
						rd.rd_addr <= rd.rd_addr + 1'b1; // data settles long before next byte
						state      <= fs_hi;
					end
				end
				fs_csum: if (can_send) begin
					tx_byte <= csum;
					tx_stb  <= 1'b1;
					state   <= fs_idle;
				end
				default: state <= fs_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* corr_top.sv */
// photon coincidence correlator top level with uart command and frame link
`timescale 1ns/100ps
`default_nettype none

module corr_top (
	input  wire                             intclk,
	input  wire                             arst_n,
	input  wire                             rx,
	input  wire [corr_pkg::num_inputs-1:0]  det_in,
	output wire                             tx,
	output wire                             integrating
);
	import corr_pkg::*;

	logic [7:0]            rx_byte;
	logic                  rx_stb;
	logic [num_inputs-1:0] invert_mask;
	logic [2:0]            window_arg;
	logic                  start;
	logic [7:0]            tx_byte;
	logic                  tx_stb;
	logic                  tx_busy;

	corr_rd_if rd_bus ();

	assign integrating = rd_bus.busy;

	// ------------------------------------------------------------------
	// command path
	// ------------------------------------------------------------------
	uart_rx u_rx (
		.intclk (intclk),
		.arst_n (arst_n),
		.rx     (rx),
		.rx_byte(rx_byte),
		.rx_stb (rx_stb)
	);

	cmd_parser u_cmd (
		.intclk     (intclk),
		.arst_n     (arst_n),
		.rx_byte    (rx_byte),
		.rx_stb     (rx_stb),
		.invert_mask(invert_mask),
		.window_arg (window_arg),
		.start      (start)
	);

	lag_correlator u_corr (
		.intclk     (intclk),
		.arst_n     (arst_n),
		.det_in     (det_in),
		.invert_mask(invert_mask),
		.window_arg (window_arg),
		.start      (start),
		.rd         (rd_bus.correlator)
	);

	// ------------------------------------------------------------------
	// result path
	// ------------------------------------------------------------------
	frame_tx u_frame (
		.intclk (intclk),
		.arst_n (arst_n),
		.rd     (rd_bus.reader),
		.tx_byte(tx_byte),
		.tx_stb (tx_stb),
		.tx_busy(tx_busy)
	);

	uart_tx u_tx (
		.intclk (intclk),
		.arst_n (arst_n),
		.tx_byte(tx_byte),
		.tx_stb (tx_stb),
		.tx     (tx),
		.tx_busy(tx_busy)
	);

endmodule

`default_nettype wire

/* tb_clock.sv */
// testbench clock source with a free running 100 ns intclk
`timescale 1ns/100ps
`default_nettype none

module tb_clock (
	output logic intclk
);

	initial intclk = 1'b0;

	always #50 intclk = ~intclk; // half period

endmodule

`default_nettype wire

/* corr_tb.sv */
// correlator testbench that runs cases from a file and checks the uart frames
`timescale 1ns/100ps
`default_nettype none

module corr_tb;
	import corr_pkg::*;

	localparam int frame_len = 55; // header, count, 26 x 2 counter bytes, checksum
	localparam int idle_gap  = 4;  // idle cycles after each command byte

	wire        intclk;
	wire        tx;
	wire        integrating;
	logic       arst_n = 1'b0;
	logic       rx     = 1'b1;
	logic [3:0] det_in = 4'h0;
	logic       tog    = 1'b0;
	logic [1:0] pat [4] = '{default: 2'd0}; // 0 low, 1 high, 2 toggle

	logic [1:0] cpat [4];          // pattern of the current case
	logic [1:0] eff  [4];          // after inversion 0 low 1 high 2 toggle 3 toggle in antiphase
	logic [7:0] frame [frame_len];
	int         win;
	int         case_errs;
	int         errors;
	int         n_pass;
	int         n_fail;
	bit         link_lost;

	tb_clock clk0 (.intclk(intclk));

	corr_top dut0 (
		.intclk     (intclk),
		.arst_n     (arst_n),
		.rx         (rx),
		.det_in     (det_in),
		.tx         (tx),
		.integrating(integrating)
	);

	// toggling detector inputs all share one phase
	always @(posedge intclk) begin
		tog <= ~tog;
		for (int i = 0; i < 4; i++)
			det_in[i] <= (pat[i] == 2'd2) ? tog : pat[i][0];
	end

	// ------------------------------------------------------------------
	// uart line helpers
	// ------------------------------------------------------------------
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0}; // stop, data lsb first, start
		for (int n = 0; n < 10; n++) begin
			@(posedge intclk);
			rx <= bits[n];
			repeat (baud_cycles - 1) @(posedge intclk);
		end
		repeat (idle_gap) @(posedge intclk);
	endtask

	task automatic wait_tx_low(input int limit, output bit found);
		found = 1'b0;
		for (int n = 0; n < limit && !found; n++) begin
			@(negedge intclk);
			if (tx == 1'b0)
				found = 1'b1;
		end
	endtask

	task automatic wait_integrating(input logic level, input int limit, output bit found);
		found = 1'b0;
		for (int n = 0; n < limit && !found; n++) begin
			@(negedge intclk);
			if (integrating === level)
				found = 1'b1;
		end
	endtask

	task automatic recv_byte(input int limit, output logic [7:0] b, output bit ok);
		bit found;
		ok = 1'b0;
		b  = 8'h00;
		wait_tx_low(limit, found);
		if (!found) begin
			$display("no start bit on tx within %0d cycles", limit);
			return;
		end
		repeat (baud_cycles / 2) @(negedge intclk); // middle of the start bit
		if (tx !== 1'b0) begin
			$display("start bit on tx ended early");
			return;
		end
		for (int n = 0; n < 8; n++) begin
			repeat (baud_cycles) @(negedge intclk);
			b[n] = tx;
		end
		repeat (baud_cycles) @(negedge intclk);
		if (tx !== 1'b1) begin
			$display("stop bit on tx was low");
			return;
		end
		ok = 1'b1;
	endtask

	task automatic recv_frame(input int first_limit, output bit ok);
		logic [7:0] b;
		ok = 1'b1;
		for (int n = 0; n < frame_len && ok; n++) begin
			recv_byte((n == 0) ? first_limit : 64, b, ok);
			frame[n] = b;
		end
	endtask

	task automatic check_quiet(input int cycles, output bit saw_tx, output bit saw_int);
		saw_tx  = 1'b0;
		saw_int = 1'b0;
		for (int n = 0; n < cycles; n++) begin
			@(negedge intclk);
			if (tx !== 1'b1)
				saw_tx = 1'b1;
			if (integrating !== 1'b0)
				saw_int = 1'b1;
		end
	endtask

	// ------------------------------------------------------------------
	// expected counts
	// ------------------------------------------------------------------
	function automatic int pulse_of(input int i);
		if (eff[i] == 2'd0)
			return 0;
		if (eff[i] == 2'd1)
			return win;
		return win / 2;
	endfunction

	function automatic int pair_of(input int a, input int b);
		if (eff[a] == 2'd0 || eff[b] == 2'd0)
			return 0;
		if (eff[a] == 2'd1 && eff[b] == 2'd1)
			return win;
		if (eff[a] == 2'd1 || eff[b] == 2'd1)
			return win / 2;
		return (eff[a] == eff[b]) ? win / 2 : 0; // in phase or antiphase
	endfunction

	function automatic int expect_count(input int idx);
		int i;
		int k;
		int p;
		if (idx < 4)
			return pulse_of(idx);
		if (idx < 20) begin
			i = (idx - 4) / 4;
			k = (idx - 4) % 4 + 1;
			if (eff[i] >= 2'd2)
				return (k % 2 == 0) ? win / 2 : 0;
			return pulse_of(i);
		end
		p = 20;
		for (int a = 0; a < 4; a++) begin
			for (int b = a + 1; b < 4; b++) begin
				if (p == idx)
					return pair_of(a, b);
				p++;
			end
		end
		return -1;
	endfunction

	task automatic check_frame();
		logic [15:0] got;
		logic [15:0] exp_v;
		logic [7:0]  x;
		if (frame[0] !== 8'hA5) begin
			$display("MISMATCH header got %h expected %h", frame[0], 8'hA5);
			case_errs++;
		end
		if (frame[1] !== 8'd26) begin
			$display("MISMATCH count got %h expected %h", frame[1], 8'd26);
			case_errs++;
		end
		for (int j = 0; j < 26; j++) begin
			got   = {frame[2 + 2 * j], frame[3 + 2 * j]}; // high byte first
			exp_v = 16'(expect_count(j));
			if (got !== exp_v) begin
				$display("MISMATCH counter[%0d] got %h expected %h", j, got, exp_v);
				case_errs++;
			end
		end
		x = 8'h00;
		for (int n = 1; n < frame_len - 1; n++)
			x = x ^ frame[n];
		if (frame[frame_len - 1] !== x) begin
			$display("MISMATCH checksum got %h expected %h", frame[frame_len - 1], x);
			case_errs++;
		end
	endtask

	// ------------------------------------------------------------------
	// case runner
	// ------------------------------------------------------------------
	initial begin
		int         fd;
		int         nf;
		int         arg;
		string      line;
		string      name;
		string      kind;
		string      pats;
		logic [7:0] mask;
		bit         ok;
		bit         seen;
		bit         saw_tx;
		bit         saw_int;

		errors    = 0;
		n_pass    = 0;
		n_fail    = 0;
		link_lost = 1'b0;
		repeat (10) @(posedge intclk);
		arst_n <= 1'b1;
		@(posedge intclk);

		fd = $fopen("corr_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open corr_cases.txt");
			errors++;
		end
		while (fd != 0 && !link_lost && !$feof(fd)) begin
			line = "";
			nf   = $fgets(line, fd);
			if (nf == 0 || line.len() < 2 || line[0] == "#")
				continue;
			nf = $sscanf(line, "%s %s %h %d %s", name, kind, mask, arg, pats);
			if (nf != 5 || pats.len() != 4) begin
				$display("malformed line in corr_cases.txt: %s", line);
				errors++;
				continue;
			end
			case_errs = 0;
			win       = base_window << arg;
			for (int i = 0; i < 4; i++) begin
				cpat[i] = (pats[i] == "T") ? 2'd2 : ((pats[i] == "1") ? 2'd1 : 2'd0);
				if (cpat[i] == 2'd2)
					eff[i] = 2'd2 + {1'b0, mask[i]};
				else
					eff[i] = cpat[i] ^ {1'b0, mask[i]};
			end
			@(posedge intclk);
			for (int i = 0; i < 4; i++)
				pat[i] <= cpat[i];

			if (kind == "I") begin
				check_quiet(200, saw_tx, saw_int);
				if (saw_tx || saw_int) begin
					$display("tx or integrating became active without a command");
					case_errs++;
				end
			end else if (kind == "U") begin
				send_byte(mask); // raw command byte
				check_quiet(1000, saw_tx, saw_int);
				if (saw_tx) begin
					$display("a frame started after an unknown opcode");
					case_errs++;
				end
				if (saw_int) begin
					$display("integrating went high after an unknown opcode");
					case_errs++;
				end
			end else begin
				send_byte({4'h1, mask[3:0]});
				send_byte({4'h2, 1'b0, 3'(arg)});
				if (kind == "D") begin
					wait_integrating(1'b1, 100, seen);
					if (!seen) begin
						$display("integrating did not rise after op_integrate");
						case_errs++;
					end
					send_byte({4'h2, 1'b0, 3'(arg)}); // lands inside the open window
					// the window opened a whole command byte earlier and must close in time
					wait_integrating(1'b0, win - (10 * baud_cycles + idle_gap) / 2, seen);
					if (!seen) begin
						$display("integrating stayed high too long after a repeated op_integrate");
						case_errs++;
					end
				end
				recv_frame(win + 3000, ok);
				if (!ok) begin
					case_errs++;
					link_lost = 1'b1;
				end else begin
					check_frame();
				end
				if (ok && kind == "D") begin
					wait_tx_low(3000, seen);
					if (seen) begin
						$display("a second frame followed a repeated op_integrate");
						case_errs++;
					end
				end
			end

			errors += case_errs;
			if (case_errs == 0) begin
				n_pass++;
				$display("case %s passed", name);
			end else begin
				n_fail++;
				$display("case %s failed with %0d errors", name, case_errs);
			end
		end
		if (fd != 0)
			$fclose(fd);

		$display("%0d cases passed, %0d cases failed", n_pass, n_fail);
		if (errors == 0 && n_fail == 0 && n_pass > 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* corr_cases.txt */
# columns: name kind mask arg pattern
# kind I idle check, N one window, D repeated integrate, U mask column is a raw command byte
# pattern is one char per input 0..3: 0 low, 1 high, T toggles every cycle
idle_after_reset   I 0  0 0000
all_high           N 0  0 1111
toggle_one         N 0  0 T111
toggle_in_phase    N 0  0 TT10
toggle_antiphase   N 2  0 TT01
invert_low         N F  0 0000
invert_high        N F  0 1111
invert_mixed       N 5  1 0011
scaled_repeat      D 0  3 1T1T
unknown_op7        U 7C 0 0000
unknown_op0        U 03 0 1111
after_unknown      N 0  0 1T0T

/* corr.f */
corr_pkg.sv
corr_rd_if.sv
uart_rx.sv
uart_tx.sv
cmd_parser.sv
lag_correlator.sv
frame_tx.sv
corr_top.sv
tb_clock.sv
corr_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := corr_tb
FILELIST  := corr.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf $(OBJ_DIR)
